// ==== hw/pdp8_defs.svh ====
// Global widths and fixed opcodes for the PDP-8 major-state control
// Bit 0 is the most significant bit of an instruction word
`ifndef PDP8_DEFS_SVH
`define PDP8_DEFS_SVH

// Instruction word width
`define WORD_W 12

// Major-state code width
`define STATE_W 5

// Interrupt IOTs, compared against the whole word
`define OP_ION 12'o6001
`define OP_IOF 12'o6002

`endif

// ==== hw/pdp8_pkg.sv ====
// Types shared by the decoder, the interrupt controller and the sequencer
// State encodings are assigned by the enum, not by the front panel
`include "pdp8_defs.svh"

package pdp8_pkg;

    typedef enum logic [`STATE_W-1:0] {
        F0, FW, F1, F2, F3,     // Fetch
        D0, DW, D1, D2, D3,     // Defer
        E0, EW, E1, E2, E3,     // Execute
        EAE0, EAE1,             // EAE loop
        H0, HW, H1, H2, H3      // Halt and panel trigger
    } major_state_t;

    typedef enum logic [2:0] {
        CLS_MRI_DIRECT,         // AND..JMS, bit 3 clear
        CLS_MRI_DEFER,          // AND..JMS, bit 3 set
        CLS_JMP_DIRECT,
        CLS_JMP_DEFER,
        CLS_IOT_OPR,            // No memory cycle
        CLS_HALT                // Group 2 with HLT bit
    } instr_class_t;

    typedef enum logic [1:0] {
        EAE_NONE,               // Normal flow
        EAE_LOOP,               // Iterates in EAE1
        EAE_DEFER               // Needs an operand cycle first
    } eae_route_t;

    typedef enum logic [1:0] {
        IOT_NONE,
        IOT_ION,
        IOT_IOF
    } iot_fn_t;

endpackage

// ==== hw/instr_decode.sv ====
// Instruction register and opcode classification
// Register loads only on the instr_valid/instr_ready handshake
`include "pdp8_defs.svh"

module instr_decode
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic [0:`WORD_W-1]       instr,
    input  logic                     instr_valid,
    input  logic                     instr_ready,
    input  logic                     eae_mode_b,   // EAE mode B selected
    output logic                     fetch_done,
    output pdp8_pkg::instr_class_t   instr_class,
    output pdp8_pkg::eae_route_t     eae_route,
    output pdp8_pkg::iot_fn_t        iot_fn
);

    logic [0:`WORD_W-1] ir;

    assign fetch_done = instr_valid & instr_ready;

    always_ff @(posedge clk)
    begin
        if (reset)
            ir <= '0;
        else if (fetch_done)
            ir <= instr;
    end

    // Major class from opcode and indirect bit
    always_comb
    begin
        if (ir[0:1] == 2'b11)
        begin
            if ({ir[0:3], ir[10:11]} == 6'b111110)   // Group 2 with HLT
                instr_class = pdp8_pkg::CLS_HALT;
            else
                instr_class = pdp8_pkg::CLS_IOT_OPR;
        end
        else if (ir[0:2] == 3'b101)                  // JMP
        begin
            if (ir[3])
                instr_class = pdp8_pkg::CLS_JMP_DEFER;
            else
                instr_class = pdp8_pkg::CLS_JMP_DIRECT;
        end
        else if (ir[3])
            instr_class = pdp8_pkg::CLS_MRI_DEFER;
        else
            instr_class = pdp8_pkg::CLS_MRI_DIRECT;
    end

    // EAE group 3 routing
    always_comb
    begin
        casez (ir)
            12'b1111??0?0101,                        // MUY
            12'b1111??0?0111:                        // DIV
                eae_route = eae_mode_b ? pdp8_pkg::EAE_DEFER : pdp8_pkg::EAE_LOOP;
            12'b111100001001,                        // NMI
            12'b1111??0?1011,                        // SHL
            12'b1111??0?1101,                        // ASR
            12'b1111??0?1111:                        // LSR
                eae_route = pdp8_pkg::EAE_LOOP;
            12'b1111??1?0011,                        // DAD
            12'b1111??1?0101:                        // DST
                eae_route = pdp8_pkg::EAE_DEFER;
            default:
                eae_route = pdp8_pkg::EAE_NONE;
        endcase
    end

    always_comb
    begin
        if (ir == `OP_ION)
            iot_fn = pdp8_pkg::IOT_ION;
        else if (ir == `OP_IOF)
            iot_fn = pdp8_pkg::IOT_IOF;
        else
            iot_fn = pdp8_pkg::IOT_NONE;
    end

endmodule

// ==== hw/int_control.sv ====
// Interrupt enable with delayed ION and immediate IOF
// Grant is combinational and already masks an IOF in progress
module int_control
(
    input  logic               clk,
    input  logic               reset,
    input  logic               int_req,      // OR of device requests
    input  pdp8_pkg::iot_fn_t  iot_fn,
    input  logic               in_f3,
    input  logic               fetch_done,
    input  logic               int_ack,
    output logic               int_ena,
    output logic               int_grant
);

    logic int_inh;  // Holds off the grant for one instruction after ION

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            int_ena <= 1'b0;
            int_inh <= 1'b0;
        end
        else
        begin
            if (fetch_done)
                int_inh <= 1'b0;                     // Next instruction fetched

            if (in_f3 && iot_fn == pdp8_pkg::IOT_ION)
            begin
                int_ena <= 1'b1;
                int_inh <= 1'b1;
            end
            else if (in_f3 && iot_fn == pdp8_pkg::IOT_IOF)
                int_ena <= 1'b0;                     // IOF acts at once

            // Taking the interrupt always wins over a late ION
            if (int_ack)
                int_ena <= 1'b0;
        end
    end

    // No grant while IOF is the current instruction
    assign int_grant = int_req & int_ena & ~int_inh &
                       (iot_fn != pdp8_pkg::IOT_IOF);

endmodule

// ==== hw/major_state_seq.sv ====
// Fetch, defer, execute, EAE and halt major-state machine
// int_ack is combinational and marks the edge that takes an interrupt
module major_state_seq
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     halt,
    input  logic                     single_step,
    input  logic                     cont,
    input  logic                     trigger,
    input  logic                     user_mode,    // UF
    input  logic                     eae_busy,
    input  logic                     instr_valid,
    input  pdp8_pkg::instr_class_t   instr_class,
    input  pdp8_pkg::eae_route_t     eae_route,
    input  logic                     int_grant,
    output logic                     instr_ready,
    output logic                     in_f3,
    output logic                     int_ack,
    output logic                     int_in_prog,
    output pdp8_pkg::major_state_t   state
);

    pdp8_pkg::major_state_t state_next;
    logic                   step_ok;     // Single step released
    logic                   take_int;

    assign step_ok     = ~single_step | cont;
    assign instr_ready = (state == pdp8_pkg::F1);
    assign in_f3       = (state == pdp8_pkg::F3);
    assign int_ack     = take_int;

    always_comb
    begin
        state_next = state;
        take_int   = 1'b0;
        case (state)
            pdp8_pkg::F0:   if (step_ok) state_next = pdp8_pkg::FW;
            pdp8_pkg::FW:   state_next = pdp8_pkg::F1;
            pdp8_pkg::F1:   if (instr_valid) state_next = pdp8_pkg::F2;  // Memory back-pressure
            pdp8_pkg::F2:
            begin
                if (eae_route == pdp8_pkg::EAE_LOOP)
                    state_next = pdp8_pkg::EAE0;
                else if (eae_route == pdp8_pkg::EAE_DEFER)
                    state_next = pdp8_pkg::D0;
                else
                    state_next = pdp8_pkg::F3;
            end
            pdp8_pkg::F3:
            begin
                if (instr_class == pdp8_pkg::CLS_MRI_DEFER ||
                    instr_class == pdp8_pkg::CLS_JMP_DEFER)
                    state_next = pdp8_pkg::D0;
                else if (instr_class == pdp8_pkg::CLS_MRI_DIRECT)
                    state_next = pdp8_pkg::E0;
                else if (halt)
                    state_next = pdp8_pkg::H0;
                else if (instr_class == pdp8_pkg::CLS_HALT && !user_mode)
                    state_next = pdp8_pkg::H0;       // HLT traps in user mode
                else if (int_grant)
                begin
                    state_next = pdp8_pkg::E0;
                    take_int   = 1'b1;
                end
                else
                    state_next = pdp8_pkg::F0;
            end
            pdp8_pkg::EAE0: state_next = pdp8_pkg::EAE1;
            pdp8_pkg::EAE1: if (!eae_busy) state_next = pdp8_pkg::F3;
            pdp8_pkg::D0:   if (step_ok) state_next = pdp8_pkg::DW;
            pdp8_pkg::DW:   state_next = pdp8_pkg::D1;
            pdp8_pkg::D1:   state_next = pdp8_pkg::D2;
            pdp8_pkg::D2:   state_next = pdp8_pkg::D3;
            pdp8_pkg::D3:
            begin
                if (instr_class != pdp8_pkg::CLS_JMP_DEFER)
                    state_next = pdp8_pkg::E0;
                else if (int_grant)                  // JMP I done, interrupt first
                begin
                    state_next = pdp8_pkg::E0;
                    take_int   = 1'b1;
                end
                else if (halt)
                    state_next = pdp8_pkg::H0;
                else
                    state_next = pdp8_pkg::F0;
            end
            pdp8_pkg::E0:   if (step_ok) state_next = pdp8_pkg::EW;
            pdp8_pkg::EW:   state_next = pdp8_pkg::E1;
            pdp8_pkg::E1:   state_next = pdp8_pkg::E2;
            pdp8_pkg::E2:   state_next = pdp8_pkg::E3;
            pdp8_pkg::E3:
            begin
                if (halt)
                    state_next = pdp8_pkg::H0;
                else if (int_in_prog)
                    state_next = pdp8_pkg::F0;       // End of interrupt cycle
                else if (int_grant)
                begin
                    state_next = pdp8_pkg::E0;
                    take_int   = 1'b1;
                end
                else
                    state_next = pdp8_pkg::F0;
            end
            pdp8_pkg::H0:   state_next = pdp8_pkg::HW;
            pdp8_pkg::HW:
            begin
                if (cont)
                    state_next = pdp8_pkg::F0;
                else if (trigger)
                    state_next = pdp8_pkg::H1;
                else
                    state_next = pdp8_pkg::H0;
            end
            pdp8_pkg::H1:   state_next = pdp8_pkg::H2;
            pdp8_pkg::H2:   state_next = pdp8_pkg::H3;
            pdp8_pkg::H3:   state_next = pdp8_pkg::H0;
            default:        state_next = pdp8_pkg::H0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state       <= pdp8_pkg::H0;
            int_in_prog <= 1'b0;
        end
        else
        begin
            state <= state_next;
            if (take_int)
                int_in_prog <= 1'b1;
            else if (state == pdp8_pkg::F0)
                int_in_prog <= 1'b0;
        end
    end

endmodule

// ==== hw/pdp8_control.sv ====
// Top of the major-state control
// Datapath, memory and devices are outside, seen only through these ports
`include "pdp8_defs.svh"

module pdp8_control
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     halt,
    input  logic                     single_step,
    input  logic                     cont,
    input  logic                     trigger,
    input  logic                     user_mode,
    input  logic                     eae_mode_b,
    input  logic                     eae_busy,
    input  logic                     int_req,
    input  logic [0:`WORD_W-1]       instr,
    input  logic                     instr_valid,
    output logic                     instr_ready,
    output pdp8_pkg::major_state_t   state,
    output logic                     int_in_prog,
    output logic                     int_ena
);

    logic                   fetch_done;
    logic                   in_f3;
    logic                   int_ack;
    logic                   int_grant;
    pdp8_pkg::instr_class_t instr_class;
    pdp8_pkg::eae_route_t   eae_route;
    pdp8_pkg::iot_fn_t      iot_fn;

    instr_decode u_decode (
        .clk(clk), .reset(reset), .instr(instr), .instr_valid(instr_valid),
        .instr_ready(instr_ready), .eae_mode_b(eae_mode_b), .fetch_done(fetch_done),
        .instr_class(instr_class), .eae_route(eae_route), .iot_fn(iot_fn)
    );

    int_control u_int (
        .clk(clk), .reset(reset), .int_req(int_req), .iot_fn(iot_fn), .in_f3(in_f3),
        .fetch_done(fetch_done), .int_ack(int_ack), .int_ena(int_ena),
        .int_grant(int_grant)
    );

    major_state_seq u_seq (
        .clk(clk), .reset(reset), .halt(halt), .single_step(single_step), .cont(cont),
        .trigger(trigger), .user_mode(user_mode), .eae_busy(eae_busy),
        .instr_valid(instr_valid), .instr_class(instr_class), .eae_route(eae_route),
        .int_grant(int_grant), .instr_ready(instr_ready), .in_f3(in_f3),
        .int_ack(int_ack), .int_in_prog(int_in_prog), .state(state)
    );

endmodule

// ==== tb/pdp8_control_tb.sv ====
// Memory is modeled by instr and instr_valid alone, with no address
// Inputs change and the state is checked on the falling clock edge
module pdp8_control_tb;

    logic clk, reset, halt, single_step, cont, trigger, user_mode;
    logic eae_mode_b, eae_busy, int_req, instr_valid;
    logic [0:11] instr;
    logic instr_ready, int_in_prog, int_ena;
    pdp8_pkg::major_state_t state;

    pdp8_pkg::major_state_t p_state;                 // State seen at last rising edge
    logic p_reset, p_cont, p_trig, p_step, p_valid, p_busy, p_halt, p_inprog;
    integer seed;
    integer hold;

    pdp8_control DUT (
        .clk(clk), .reset(reset), .halt(halt), .single_step(single_step), .cont(cont),
        .trigger(trigger), .user_mode(user_mode), .eae_mode_b(eae_mode_b),
        .eae_busy(eae_busy), .int_req(int_req), .instr(instr), .instr_valid(instr_valid),
        .instr_ready(instr_ready), .state(state), .int_in_prog(int_in_prog),
        .int_ena(int_ena)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic fail_value(input string name, input logic [11:0] exp, input logic [11:0] got);
        $display("ERR %s expected %h got %h", name, exp, got);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic expect_next(input pdp8_pkg::major_state_t s);
        @(negedge clk);
        assert (state == s) else fail_value("state", 12'(s), 12'(state));
    endtask

    task automatic wait_state(input pdp8_pkg::major_state_t s);
        integer n;
        n = 0;
        while (state != s && n < 60)
        begin
            @(negedge clk);
            n = n + 1;
        end
        if (state != s)
        begin
            $display("Timed out waiting for major state %0d", s);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // Stays in s under single step until cont releases it to nxt
    task automatic step_through(input pdp8_pkg::major_state_t s,
                                input pdp8_pkg::major_state_t nxt);
        repeat (3) expect_next(s);
        cont = 1'b1;
        expect_next(nxt);
        cont = 1'b0;
    endtask

    task automatic resume_from_halt();
        wait_state(pdp8_pkg::HW);
        cont = 1'b1;
        expect_next(pdp8_pkg::F0);
        cont = 1'b0;
    endtask

    // Mode B EAE path through an operand cycle and execute
    task automatic defer_path();
        wait_state(pdp8_pkg::F2);
        expect_next(pdp8_pkg::D0);
        wait_state(pdp8_pkg::D3);
        expect_next(pdp8_pkg::E0);
        wait_state(pdp8_pkg::E3);
        expect_next(pdp8_pkg::F0);
    endtask

    always @(posedge clk)
    begin
        p_state  = state;
        p_reset  = reset;
        p_cont   = cont;
        p_trig   = trigger;
        p_step   = ~single_step | cont;
        p_valid  = instr_valid;
        p_busy   = eae_busy;
        p_halt   = halt;
        p_inprog = int_in_prog;
    end

    // Transition rules that do not depend on the instruction class
    always @(negedge clk)
    begin
        pdp8_pkg::major_state_t exp_state;
        logic                   known;
        if (p_reset === 1'b0)
        begin
            assert (instr_ready == (state == pdp8_pkg::F1))
                else fail_value("instr_ready", 12'(state == pdp8_pkg::F1), 12'(instr_ready));
            known     = 1'b1;
            exp_state = p_state;
            case (p_state)
                pdp8_pkg::H0:
                    exp_state = pdp8_pkg::HW;
                pdp8_pkg::H3:
                    exp_state = pdp8_pkg::H0;
                pdp8_pkg::HW:
                begin
                    if (p_cont)
                        exp_state = pdp8_pkg::F0;
                    else if (p_trig)
                        exp_state = pdp8_pkg::H1;
                    else
                        exp_state = pdp8_pkg::H0;
                end
                pdp8_pkg::F0, pdp8_pkg::D0, pdp8_pkg::E0:
                    if (p_step)
                        exp_state = p_state.next();  // Step gate
                pdp8_pkg::F1:
                    if (p_valid)
                        exp_state = pdp8_pkg::F2;
                pdp8_pkg::FW, pdp8_pkg::DW, pdp8_pkg::D1, pdp8_pkg::D2, pdp8_pkg::EW,
                pdp8_pkg::E1, pdp8_pkg::E2, pdp8_pkg::EAE0, pdp8_pkg::H1, pdp8_pkg::H2:
                    exp_state = p_state.next();
                pdp8_pkg::EAE1:
                    if (!p_busy)
                        exp_state = pdp8_pkg::F3;
                pdp8_pkg::E3:
                begin
                    if (p_halt)
                        exp_state = pdp8_pkg::H0;
                    else if (p_inprog)
                        exp_state = pdp8_pkg::F0;
                    else
                        known = 1'b0;
                end
                default:
                    known = 1'b0;
            endcase
            if (known)
                assert (state == exp_state)
                    else fail_value("state", 12'(exp_state), 12'(state));
        end
    end

    initial
    begin
        seed = 32'hd1733fa3;
        p_reset = 1'b1;
        {halt, single_step, cont, trigger, user_mode} = '0;
        {eae_mode_b, eae_busy, int_req, instr_valid} = '0;
        instr = '0;
        reset = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        assert (state == pdp8_pkg::H0) else fail_value("state", 12'(pdp8_pkg::H0), 12'(state));
        assert (!instr_ready) else fail_value("instr_ready", 12'h0, 12'(instr_ready));
        assert (!int_ena) else fail_value("int_ena", 12'h0, 12'(int_ena));

        // Halt loop and panel trigger
        expect_next(pdp8_pkg::HW);
        expect_next(pdp8_pkg::H0);
        expect_next(pdp8_pkg::HW);
        trigger = 1'b1;
        expect_next(pdp8_pkg::H1);
        trigger = 1'b0;
        expect_next(pdp8_pkg::H2);
        expect_next(pdp8_pkg::H3);
        expect_next(pdp8_pkg::H0);
        resume_from_halt();

        // TAD direct with slow memory
        instr = 12'o1000;
        instr_valid = 1'b0;
        wait_state(pdp8_pkg::F1);
        hold = 3 + ($random(seed) & 3);
        repeat (hold) expect_next(pdp8_pkg::F1);
        instr_valid = 1'b1;
        expect_next(pdp8_pkg::F2);
        expect_next(pdp8_pkg::F3);
        expect_next(pdp8_pkg::E0);
        wait_state(pdp8_pkg::E3);
        expect_next(pdp8_pkg::F0);

        // TAD I under single step
        single_step = 1'b1;
        instr = 12'o1400;
        step_through(pdp8_pkg::F0, pdp8_pkg::FW);
        wait_state(pdp8_pkg::D0);
        step_through(pdp8_pkg::D0, pdp8_pkg::DW);
        wait_state(pdp8_pkg::D3);
        expect_next(pdp8_pkg::E0);
        step_through(pdp8_pkg::E0, pdp8_pkg::EW);
        wait_state(pdp8_pkg::E3);
        expect_next(pdp8_pkg::F0);
        single_step = 1'b0;

        // JMP I, then HLT outside and inside user mode
        instr = 12'o5400;
        wait_state(pdp8_pkg::D3);
        expect_next(pdp8_pkg::F0);
        instr = 12'o7402;
        wait_state(pdp8_pkg::F3);
        expect_next(pdp8_pkg::H0);
        resume_from_halt();
        user_mode = 1'b1;
        wait_state(pdp8_pkg::F3);
        expect_next(pdp8_pkg::F0);
        user_mode = 1'b0;

        // MUY in mode A held busy in the EAE loop, then SHL
        eae_busy = 1'b1;
        instr = 12'o7405;
        wait_state(pdp8_pkg::F2);
        expect_next(pdp8_pkg::EAE0);
        repeat (4) expect_next(pdp8_pkg::EAE1);
        eae_busy = 1'b0;
        expect_next(pdp8_pkg::F3);
        expect_next(pdp8_pkg::F0);
        instr = 12'o7413;
        wait_state(pdp8_pkg::F2);
        expect_next(pdp8_pkg::EAE0);
        expect_next(pdp8_pkg::EAE1);
        expect_next(pdp8_pkg::F3);
        expect_next(pdp8_pkg::F0);

        // Mode B MUY and DST take a defer cycle
        eae_mode_b = 1'b1;
        instr = 12'o7405;
        defer_path();
        instr = 12'o7445;
        defer_path();
        eae_mode_b = 1'b0;

        // ION is delayed by one instruction
        int_req = 1'b1;
        instr = 12'o6001;
        wait_state(pdp8_pkg::F3);
        expect_next(pdp8_pkg::F0);
        assert (int_ena) else fail_value("int_ena", 12'h1, 12'(int_ena));
        instr = 12'o7000;
        wait_state(pdp8_pkg::F3);
        expect_next(pdp8_pkg::E0);
        assert (int_in_prog) else fail_value("int_in_prog", 12'h1, 12'(int_in_prog));
        assert (!int_ena) else fail_value("int_ena", 12'h0, 12'(int_ena));
        wait_state(pdp8_pkg::E3);
        expect_next(pdp8_pkg::F0);

        // IOF right after ION blocks the request
        instr = 12'o6001;
        wait_state(pdp8_pkg::F3);
        expect_next(pdp8_pkg::F0);
        instr = 12'o6002;
        wait_state(pdp8_pkg::F3);
        expect_next(pdp8_pkg::F0);
        assert (!int_ena) else fail_value("int_ena", 12'h0, 12'(int_ena));
        assert (!int_in_prog) else fail_value("int_in_prog", 12'h0, 12'(int_in_prog));
        int_req = 1'b0;

        // Halt switch at F3, D3 and E3
        halt = 1'b1;
        instr = 12'o7000;
        wait_state(pdp8_pkg::F3);
        expect_next(pdp8_pkg::H0);
        resume_from_halt();
        instr = 12'o5400;
        wait_state(pdp8_pkg::D3);
        expect_next(pdp8_pkg::H0);
        resume_from_halt();
        instr = 12'o1000;
        wait_state(pdp8_pkg::E3);
        expect_next(pdp8_pkg::H0);
        halt = 1'b0;

        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== pdp8_control.f ====
+incdir+hw
hw/pdp8_pkg.sv
hw/instr_decode.sv
hw/int_control.sv
hw/major_state_seq.sv
hw/pdp8_control.sv
tb/pdp8_control_tb.sv

// ==== Makefile ====
# Verilator build and run for the PDP-8 major-state control

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, pass if the log holds the pass message"
	@echo "  clean  remove build output and the log"
	@echo "  help   list these targets"

test:
	verilator --binary --timing -f pdp8_control.f --top-module pdp8_control_tb -o sim_tb
	./obj_dir/sim_tb > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
